//--- vlog.f
hdl/adc_pkg.sv
hdl/adc_conv_model.sv
hdl/adc_eoc_sync.sv
hdl/adc_conv_sequencer.sv
hdl/adc_avalon_slave.sv
hdl/adc_top.sv
sim/tb_adc_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ADC testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_adc_top -Mdir obj_dir -o tb_adc_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_adc_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- sim/tb_adc_top.sv
`timescale 1ns/1ps

module tb_adc_top;

    localparam int clk_half = 20;   // 40 ns bus clock.
    localparam int adc_half = 50;   // 100 ns converter clock.
    localparam int max_wait = 400;  // clk cycles per wait loop.

    logic                       clk;
    logic                       rst_n;
    logic                       adc_clk;
    logic                       read;
    logic                       write;
    logic [adc_pkg::addr_w-1:0] address;
    logic [adc_pkg::data_w-1:0] writedata;
    logic [adc_pkg::data_w-1:0] readdata;
    logic                       waitrequest;
    logic                       readdatavalid;

    int          err_cnt;      // wrong values and failed properties.
    int          timeout_cnt;  // waits that ran out.
    int          n_acc;        // reads accepted by the slave.
    int          n_rdv;        // readdatavalid pulses seen.
    logic        data_out;     // data read in flight.
    logic [3:0]  exp_chan;     // channel the slave should hold.
    logic [7:0]  exp_conv;     // converter's conversion number, mod 256.
    logic [15:0] exp_count;    // completed data reads.

    adc_top i_adc_top (
        .clk(clk), .rst_n(rst_n), .adc_clk(adc_clk),
        .read(read), .write(write), .address(address), .writedata(writedata),
        .readdata(readdata), .waitrequest(waitrequest), .readdatavalid(readdatavalid)
    );

    always #(clk_half) clk = ~clk;
    always #(adc_half) adc_clk = ~adc_clk;

    // bus bookkeeping sampled like the dut does.
    always @(posedge clk) begin
        if (!rst_n) begin
            n_acc    <= 0;
            n_rdv    <= 0;
            data_out <= 1'b0;
        end else begin
            if (readdatavalid) begin
                n_rdv    <= n_rdv + 1;
                data_out <= 1'b0;
            end
            if (read && !waitrequest) begin
                n_acc <= n_acc + 1;
                if (address == adc_pkg::reg_data)
                    data_out <= 1'b1; // conversion pending.
            end
        end
    end

    // back-pressure must hold for the whole data read.
    assert property (@(posedge clk) disable iff (!rst_n) data_out |-> waitrequest)
        else begin
            err_cnt++;
            $display("waitrequest went low while a data read was outstanding");
        end

    // each pulse answers exactly one accepted read.
    assert property (@(posedge clk) disable iff (!rst_n) readdatavalid |-> n_acc == n_rdv + 1)
        else begin
            err_cnt++;
            $display("readdatavalid pulsed with no accepted read waiting for it");
        end

    assert property (@(posedge clk) disable iff (!rst_n) n_acc >= n_rdv && n_acc <= n_rdv + 1)
        else begin
            err_cnt++;
            $display("more than one read in flight, or a pulse without a read");
        end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // returns after the edge that accepts the transfer.
    task automatic wait_accept(input string what, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < max_wait; n++) begin
            @(negedge clk);
            if (!waitrequest) begin
                ok = 1'b1;
                break;
            end
        end
        @(posedge clk);
        if (!ok) begin
            timeout_cnt++;
            $display("timed out waiting for waitrequest to drop on %s", what);
        end
    endtask

    task automatic write_reg(input logic [9:0] addr, input logic [15:0] data);
        bit ok;
        @(posedge clk);
        write     <= 1'b1;
        address   <= addr;
        writedata <= data;
        wait_accept("a write", ok);
        write <= 1'b0;
    endtask

    // lat counts clk cycles from acceptance to readdatavalid.
    task automatic read_reg(input logic [9:0] addr, output logic [15:0] data,
                            output int lat);
        bit ok;
        int n;
        data = 'x;
        lat  = 0;
        @(posedge clk);
        read    <= 1'b1;
        address <= addr;
        wait_accept("a read", ok);
        read <= 1'b0;
        if (ok) begin
            ok = 1'b0;
            for (n = 0; n < max_wait; n++) begin
                @(negedge clk);
                lat++;
                if (readdatavalid) begin
                    ok = 1'b1;
                    break;
                end
            end
            if (ok)
                data = readdata; // stable mid cycle.
            else begin
                timeout_cnt++;
                $display("timed out waiting for readdatavalid at address %0d", addr);
            end
        end
    endtask

    // one conversion through the data register.
    task automatic convert_once();
        logic [15:0] rd;
        int lat;
        read_reg(adc_pkg::reg_data, rd, lat);
        check_value("data read", {4'h0, exp_chan, exp_conv}, rd);
        exp_conv  = exp_conv + 8'd1;
        exp_count = exp_count + 16'd1;
    endtask

    initial begin
        int unsigned pick;
        int          k;
        int          lat;
        logic [15:0] rd;
        logic [15:0] wd;
        clk         = 1'b0;
        adc_clk     = 1'b0;
        rst_n       = 1'b0;
        read        = 1'b0;
        write       = 1'b0;
        address     = '0;
        writedata   = '0;
        err_cnt     = 0;
        timeout_cnt = 0;
        exp_chan    = '0;
        exp_conv    = '0;
        exp_count   = '0;
        void'($urandom(32'hf4ad43f7));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(posedge clk); // adc_clk side leaves reset.

        // reset values.
        @(negedge clk);
        check_value("reset waitrequest", 16'h0, 16'(waitrequest));
        check_value("reset readdatavalid", 16'h0, 16'(readdatavalid));
        read_reg(adc_pkg::reg_ctrl, rd, lat);
        check_value("reset ctrl", 16'h0, rd);
        check_value("ctrl latency", 16'd1, 16'(lat));
        read_reg(adc_pkg::reg_count, rd, lat);
        check_value("reset count", 16'h0, rd);

        // random mix of channel writes, conversions and count reads.
        for (k = 0; k < 30; k++) begin
            pick = $urandom_range(3, 0);
            if (pick == 0 || k == 0) begin
                wd = 16'($urandom); // upper bits must read back as zero.
                write_reg(adc_pkg::reg_ctrl, wd);
                exp_chan = wd[3:0];
                read_reg(adc_pkg::reg_ctrl, rd, lat);
                check_value("ctrl readback", {12'h0, exp_chan}, rd);
            end else if (pick == 3) begin
                read_reg(adc_pkg::reg_count, rd, lat);
                check_value("count read", exp_count, rd);
                check_value("count latency", 16'd1, 16'(lat));
            end else begin
                convert_once();
            end
        end
        read_reg(adc_pkg::reg_count, rd, lat);
        check_value("final count", exp_count, rd);

        // unmapped read, then a write the count must ignore.
        read_reg(adc_pkg::addr_w'($urandom_range(1023, 3)), rd, lat);
        check_value("unmapped read", 16'h0, rd);
        check_value("unmapped latency", 16'd1, 16'(lat));
        write_reg(adc_pkg::reg_count, 16'hbeef);
        read_reg(adc_pkg::reg_count, rd, lat);
        check_value("count after write", exp_count, rd);
        convert_once(); // converter still follows after that.

        repeat (4) @(posedge clk);
        check_value("reads vs pulses", 16'(n_acc), 16'(n_rdv));
        $display("done: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_adc_top

//--- hdl/adc_top.sv
`timescale 1ns/1ps

// adc sampling subsystem from bus slave down to converter.
module adc_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       adc_clk,
    input  logic                       read,
    input  logic                       write,
    input  logic [adc_pkg::addr_w-1:0] address,
    input  logic [adc_pkg::data_w-1:0] writedata,
    output logic [adc_pkg::data_w-1:0] readdata,
    output logic                       waitrequest,
    output logic                       readdatavalid
);

    logic                         conv_valid;     // slave request.
    logic                         conv_ready;     // sequencer idle.
    logic [adc_pkg::chan_w-1:0]   conv_chan;
    logic                         result_valid;   // result pulse.
    logic [adc_pkg::sample_w-1:0] result_sample;
    logic                         soc;            // to adc.
    logic [adc_pkg::chan_w-1:0]   chsel;
    logic                         eoc;            // adc_clk domain.
    logic [adc_pkg::sample_w-1:0] dout;           // adc_clk domain.
    logic                         eoc_level;      // clk domain.
    logic                         eoc_rise;
    logic [adc_pkg::sample_w-1:0] sample;

    adc_avalon_slave i_adc_avalon_slave (
        .clk(clk), .rst_n(rst_n),
        .read(read), .write(write), .address(address), .writedata(writedata),
        .readdata(readdata), .waitrequest(waitrequest), .readdatavalid(readdatavalid),
        .conv_valid(conv_valid), .conv_ready(conv_ready), .conv_chan(conv_chan),
        .result_valid(result_valid), .result_sample(result_sample)
    );

    adc_conv_sequencer i_adc_conv_sequencer (
        .clk(clk), .rst_n(rst_n),
        .conv_valid(conv_valid), .conv_ready(conv_ready), .conv_chan(conv_chan),
        .result_valid(result_valid), .result_sample(result_sample),
        .soc(soc), .chsel(chsel),
        .eoc_level(eoc_level), .eoc_rise(eoc_rise), .sample(sample)
    );

    adc_eoc_sync i_adc_eoc_sync (
        .clk(clk), .rst_n(rst_n), .eoc(eoc), .dout(dout),
        .eoc_level(eoc_level), .eoc_rise(eoc_rise), .sample(sample)
    );

    // swap for the vendor cell in a real build.
    adc_conv_model i_adc_conv_model (
        .adc_clk(adc_clk), .rst_n(rst_n), .soc(soc), .chsel(chsel),
        .eoc(eoc), .dout(dout)
    );

endmodule : adc_top

//--- hdl/adc_avalon_slave.sv
`timescale 1ns/1ps

// avalon-mm slave with a data, control and count register.
// data reads have variable latency, others answer one cycle later.
module adc_avalon_slave (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         read,
    input  logic                         write,
    input  logic [adc_pkg::addr_w-1:0]   address,
    input  logic [adc_pkg::data_w-1:0]   writedata,
    output logic [adc_pkg::data_w-1:0]   readdata,
    output logic                         waitrequest,
    output logic                         readdatavalid,
    output logic                         conv_valid,
    input  logic                         conv_ready,
    output logic [adc_pkg::chan_w-1:0]   conv_chan,
    input  logic                         result_valid,
    input  logic [adc_pkg::sample_w-1:0] result_sample
);

    logic                         busy;        // data read outstanding.
    logic [adc_pkg::chan_w-1:0]   ctrl_chan;   // control register.
    logic [adc_pkg::data_w-1:0]   conv_count;  // completed conversions, wraps.
    logic                         rd_acc;      // read accepted this cycle.
    logic                         wr_acc;      // write accepted this cycle.

    assign waitrequest = busy; // stays up through the readdatavalid cycle.
    assign rd_acc      = read & ~busy;
    assign wr_acc      = write & ~busy;
    assign conv_chan   = ctrl_chan; // writes are held off while busy.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            conv_valid    <= 1'b0;
            readdatavalid <= 1'b0;
            ctrl_chan     <= '0;
            conv_count    <= '0;
        end else begin
            readdatavalid <= 1'b0;
            if (conv_valid && conv_ready)
                conv_valid <= 1'b0; // request taken.
            if (result_valid) begin
                readdatavalid <= 1'b1;
                conv_count    <= conv_count + 1'b1;
            end
            if (busy && readdatavalid)
                busy <= 1'b0; // data read done.
            if (rd_acc) begin
                if (address == adc_pkg::reg_data) begin
                    busy       <= 1'b1;
                    conv_valid <= 1'b1; // held until sequencer is idle.
                end else begin
                    readdatavalid <= 1'b1; // register read answers next cycle.
                end
            end
            if (wr_acc && address == adc_pkg::reg_ctrl)
                ctrl_chan <= writedata[adc_pkg::chan_w-1:0];
        end
    end

    // read data mux.
    always_ff @(posedge clk) begin
        if (result_valid) begin
            readdata <= {{(adc_pkg::data_w - adc_pkg::sample_w){1'b0}}, result_sample};
        end else if (rd_acc) begin
            case (address)
                adc_pkg::reg_ctrl:
                    readdata <= {{(adc_pkg::data_w - adc_pkg::chan_w){1'b0}}, ctrl_chan};
                adc_pkg::reg_count:
                    readdata <= conv_count;
                default:
                    readdata <= '0; // zero for unmapped reads and pending data.
            endcase
        end
    end

endmodule : adc_avalon_slave

//--- hdl/adc_conv_sequencer.sv
`timescale 1ns/1ps

// soc/eoc handshake with the adc.
// one request in, one result pulse out.
module adc_conv_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         conv_valid,
    output logic                         conv_ready,
    input  logic [adc_pkg::chan_w-1:0]   conv_chan,
    output logic                         result_valid,
    output logic [adc_pkg::sample_w-1:0] result_sample,
    output logic                         soc,
    output logic [adc_pkg::chan_w-1:0]   chsel,
    input  logic                         eoc_level,
    input  logic                         eoc_rise,
    input  logic [adc_pkg::sample_w-1:0] sample
);

    // idle -> converting -> releasing -> draining -> idle.
    enum logic [1:0] {
        idle,        // waiting for a request.
        converting,  // soc high, waiting for eoc.
        releasing,   // drop soc.
        draining     // wait for eoc low again.
    } state;

    assign conv_ready = (state == idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= idle;
            soc          <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0; // single cycle pulse.
            case (state)
                idle: begin
                    if (conv_valid) begin
                        soc   <= 1'b1;
                        state <= converting;
                    end
                end
                converting: begin
                    if (eoc_rise) begin
                        result_valid <= 1'b1; // sample is latched this cycle.
                        state        <= releasing;
                    end
                end
                releasing: begin
                    soc   <= 1'b0; // eoc seen, let go.
                    state <= draining;
                end
                draining: begin
                    if (!eoc_level)
                        state <= idle; // adc ready for next soc.
                end
                default: state <= idle;
            endcase
        end
    end

    // payload held for the whole conversion.
    always_ff @(posedge clk) begin
        if (state == idle && conv_valid)
            chsel <= conv_chan;
        if (state == converting && eoc_rise)
            result_sample <= sample;
    end

endmodule : adc_conv_sequencer

//--- hdl/adc_eoc_sync.sv
`timescale 1ns/1ps

// eoc crossing from adc_clk into clk.
// dout is sampled only after the rise has gone through the chain.
module adc_eoc_sync (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         eoc,
    input  logic [adc_pkg::sample_w-1:0] dout,
    output logic                         eoc_level,
    output logic                         eoc_rise,
    output logic [adc_pkg::sample_w-1:0] sample
);

    logic [adc_pkg::sync_stages-1:0] sync_q;  // synchronizer chain.
    logic                            eoc_q;   // last synced level, for edge.
    logic                            rise_d;  // rise seen this cycle.

    assign eoc_level = sync_q[adc_pkg::sync_stages-1];
    assign rise_d    = eoc_level & ~eoc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q   <= '0;
            eoc_q    <= 1'b0;
            eoc_rise <= 1'b0;
        end else begin
            sync_q   <= {sync_q[adc_pkg::sync_stages-2:0], eoc}; // shift in.
            eoc_q    <= eoc_level;
            eoc_rise <= rise_d; // sync_stages+1 cycles after eoc.
        end
    end

    // dout has been settled for sync_stages cycles by now.
    always_ff @(posedge clk) begin
        if (rise_d)
            sample <= dout;
    end

endmodule : adc_eoc_sync

//--- hdl/adc_conv_model.sv
`timescale 1ns/1ps

// behavioral stand-in for the hard adc block.
// dout is {chsel, low 8 bits of conversion number}.
// conversion number starts at 0 after reset.
module adc_conv_model (
    input  logic                         adc_clk,
    input  logic                         rst_n,
    input  logic                         soc,
    input  logic [adc_pkg::chan_w-1:0]   chsel,
    output logic                         eoc,
    output logic [adc_pkg::sample_w-1:0] dout
);

    logic                                            rst_meta;  // first reset flop.
    logic                                            rst_sync;  // reset seen in adc_clk.
    logic                                            busy;      // conversion running.
    logic [$clog2(adc_pkg::conv_cycles)-1:0]         cnt;       // edges since soc sampled.
    logic [adc_pkg::chan_w-1:0]                      chan_q;    // channel held per conversion.
    logic [adc_pkg::sample_w-adc_pkg::chan_w-1:0]    conv_num;  // wraps at 256.

    // bring rst_n into the adc_clk domain.
    always_ff @(posedge adc_clk) begin
        rst_meta <= rst_n;
        rst_sync <= rst_meta;
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_sync) begin
            busy     <= 1'b0;
            cnt      <= '0;
            eoc      <= 1'b0;
            conv_num <= '0;
        end else if (busy) begin
            if (cnt == adc_pkg::conv_cycles - 1) begin // last edge of conversion.
                busy     <= 1'b0;
                eoc      <= 1'b1;
                conv_num <= conv_num + 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (eoc) begin
            if (!soc)
                eoc <= 1'b0; // falls one edge after soc drops.
        end else if (soc) begin
            busy <= 1'b1; // soc sampled, start counting.
            cnt  <= '0;
        end
    end

    // channel and result word.
    always_ff @(posedge adc_clk) begin
        if (!busy && !eoc && soc)
            chan_q <= chsel; // take channel with soc.
        if (busy && cnt == adc_pkg::conv_cycles - 1)
            dout <= {chan_q, conv_num}; // stable until next soc.
    end

endmodule : adc_conv_model

//--- hdl/adc_pkg.sv
package adc_pkg;

    // bus side widths.
    localparam int addr_w = 10;   // word address.
    localparam int data_w = 16;   // read and write data.

    // converter side widths.
    localparam int sample_w = 12; // one adc result.
    localparam int chan_w   = 4;  // channel 0 to 15.

    // register map in word addresses.
    localparam logic [addr_w-1:0] reg_data  = addr_w'(0); // read starts a conversion.
    localparam logic [addr_w-1:0] reg_ctrl  = addr_w'(1); // channel select.
    localparam logic [addr_w-1:0] reg_count = addr_w'(2); // completed conversions.

    // behavioral converter timing.
    // adc_clk edges from a sampled soc to the eoc rise.
    localparam int conv_cycles = 6;

    // flops in the eoc crossing into clk.
    localparam int sync_stages = 2;

endpackage : adc_pkg
